//--- design/bwc_sys_params.svh
`ifndef BWC_SYS_PARAMS_SVH
`define BWC_SYS_PARAMS_SVH

// ==================================================
// Stream widths
// ==================================================
`define BWC_IN_W          64   // Input beat data bits
`define BWC_OUT_W         128  // Output beat data bits
`define BWC_CACHE_W       192  // Bit cache, input plus output width

// ==================================================
// Register port
// ==================================================
`define BWC_WB_AW         4    // Word address bits

// Register word addresses
`define BWC_REG_CTRL      0    // Start and flush pulses
`define BWC_REG_WIDTH     1    // in_bw and out_bw
`define BWC_REG_STATUS    2    // State, busy, frames done
`define BWC_REG_IN_BEATS  3    // Input beats of the frame
`define BWC_REG_OUT_BEATS 4    // Output beats of the frame

`endif

//--- design/bwc_stream_pkg.sv
`default_nettype none
`include "bwc_sys_params.svh"

package bwc_stream_pkg;

    // ==================================================
    // Width typedefs
    // ==================================================
    typedef logic [$clog2(`BWC_IN_W):0]      in_bw_t;    // 0 to 64 valid input bits
    typedef logic [$clog2(`BWC_OUT_W):0]     out_bw_t;   // 0 to 128 valid output bits
    typedef logic [$clog2(`BWC_CACHE_W)-1:0] fill_t;     // Cache occupancy

    typedef logic [`BWC_IN_W-1:0]            in_data_t;  // Raw input word
    typedef logic [`BWC_OUT_W-1:0]           out_data_t; // Packed output word
    typedef logic [`BWC_CACHE_W-1:0]         cache_t;    // Bit cache image

    // ==================================================
    // Stream beats
    // ==================================================
    typedef struct packed {
        in_data_t data;  // Low in_bw bits are payload
        logic     last;  // Final beat of the frame
    } in_beat_t;

    typedef struct packed {
        out_data_t data; // Bits above out_bw read as zero
        logic      last; // Final packed beat
    } out_beat_t;

endpackage

`default_nettype wire

//--- design/bwc_ctrl_pkg.sv
`default_nettype none
`include "bwc_sys_params.svh"

package bwc_ctrl_pkg;

    // ==================================================
    // Controller and register map
    // ==================================================
    typedef enum logic [1:0] {
        IDLE  = 2'd0,  // Waiting for start
        RUN   = 2'd1,  // Accepting input beats
        DRAIN = 2'd2,  // Last input taken, emptying cache
        FLUSH = 2'd3   // One cycle cache clear
    } ctrl_state_e;

    typedef enum logic [2:0] {
        REG_CTRL      = `BWC_REG_CTRL,
        REG_WIDTH     = `BWC_REG_WIDTH,
        REG_STATUS    = `BWC_REG_STATUS,
        REG_IN_BEATS  = `BWC_REG_IN_BEATS,
        REG_OUT_BEATS = `BWC_REG_OUT_BEATS
    } reg_idx_e;

    typedef logic [15:0] beat_cnt_t;   // Beats per frame
    typedef logic [7:0]  frame_cnt_t;  // Completed frames, wraps

    typedef struct packed {
        bwc_stream_pkg::in_bw_t  in_bw;   // WIDTH[6:0]
        bwc_stream_pkg::out_bw_t out_bw;  // WIDTH[15:8]
        logic                    start;   // CTRL[0] write pulse
        logic                    flush;   // CTRL[1] write pulse
    } bwc_cfg_t;

    typedef struct packed {
        ctrl_state_e state;
        logic        busy;        // Any state but IDLE
        frame_cnt_t  frames_done;
        beat_cnt_t   in_beats;
        beat_cnt_t   out_beats;
    } bwc_stat_t;

endpackage

`default_nettype wire

//--- design/bwc_csr.sv
`default_nettype none
`include "bwc_sys_params.svh"

module bwc_csr (
    input  wire                          CLK,
    input  wire                          RST_N,
    input  wire                          wb_cyc,
    input  wire                          wb_stb,
    input  wire                          wb_we,
    input  wire [`BWC_WB_AW-1:0]         wb_adr,
    input  wire [31:0]                   wb_dat_w,
    input  wire [3:0]                    wb_sel,
    input  wire bwc_ctrl_pkg::bwc_stat_t stat,
    output logic [31:0]                  wb_dat_r,
    output logic                         wb_ack,
    output bwc_ctrl_pkg::bwc_cfg_t       cfg
);
    import bwc_ctrl_pkg::*;
    import bwc_stream_pkg::*;

    in_bw_t      width_in_q;   // Stored in_bw
    out_bw_t     width_out_q;  // Stored out_bw
    logic        start_q;      // Start pulse, high in ack cycle
    logic        flush_q;      // Flush pulse, high in ack cycle
    logic        req;          // Fresh request this cycle
    logic        wr_en;        // Full word write accepted
    logic        adr_ok;       // Address inside register window
    reg_idx_e    idx;
    logic [31:0] rd_word;

    // ==================================================
    // Request decode
    // ==================================================
    assign req    = wb_cyc & wb_stb & ~wb_ack;  // Ack cycle blocks a repeat
    assign wr_en  = req & wb_we & (&wb_sel);    // Only whole word writes land
    assign adr_ok = (wb_adr[`BWC_WB_AW-1:3] == '0);
    assign idx    = reg_idx_e'(wb_adr[2:0]);

    always_comb begin
        rd_word = '0;
        if (adr_ok) begin
            case (idx)
                REG_CTRL:      rd_word = '0;  // Pulse bits read as zero
                REG_WIDTH:     rd_word = {16'd0, width_out_q, 1'b0, width_in_q};
                REG_STATUS:    rd_word = {16'd0, stat.frames_done, 5'd0,
                                          stat.busy, stat.state};
                REG_IN_BEATS:  rd_word = {16'd0, stat.in_beats};
                REG_OUT_BEATS: rd_word = {16'd0, stat.out_beats};
                default:       rd_word = '0;  // Unmapped words
            endcase
        end
    end

    // ==================================================
    // Registers and ack
    // ==================================================
    always_ff @(posedge CLK or negedge RST_N) begin
        if (!RST_N) begin
            wb_ack      <= 1'b0;
            start_q     <= 1'b0;
            flush_q     <= 1'b0;
            width_in_q  <= in_bw_t'(`BWC_IN_W);   // Full width by default
            width_out_q <= out_bw_t'(`BWC_OUT_W);
        end else begin
            wb_ack  <= req;                       // One cycle after request
            start_q <= wr_en & adr_ok & (idx == REG_CTRL) & wb_dat_w[0];
            flush_q <= wr_en & adr_ok & (idx == REG_CTRL) & wb_dat_w[1];
            if (wr_en && adr_ok && idx == REG_WIDTH) begin
                width_in_q  <= wb_dat_w[6:0];
                width_out_q <= wb_dat_w[15:8];
            end
        end
    end

    // Read data captured with the ack
    always_ff @(posedge CLK) begin
        if (req) begin
            wb_dat_r <= rd_word;
        end
    end

    assign cfg = '{in_bw:  width_in_q,
                   out_bw: width_out_q,
                   start:  start_q,
                   flush:  flush_q};

endmodule

`default_nettype wire

//--- design/bwc_ctrl.sv
`default_nettype none
`include "bwc_sys_params.svh"

module bwc_ctrl (
    input  wire                         CLK,
    input  wire                         RST_N,
    input  wire bwc_ctrl_pkg::bwc_cfg_t cfg,
    input  wire                         in_vld,
    input  wire                         in_last,   // Last flag of the offered beat
    input  wire                         pk_in_rdy,
    input  wire                         out_fire,
    input  wire                         out_last,
    output logic                        pk_in_vld,
    output logic                        in_rdy,
    output logic                        pk_clear,
    output bwc_stream_pkg::in_bw_t      run_in_bw,
    output bwc_stream_pkg::out_bw_t     run_out_bw,
    output bwc_ctrl_pkg::bwc_stat_t     stat
);
    import bwc_ctrl_pkg::*;
    import bwc_stream_pkg::*;

    ctrl_state_e state_q;
    ctrl_state_e state_d;
    logic        running;    // Input side open
    logic        in_fire;    // Input beat taken by packer
    logic        frame_end;  // Last output beat taken
    logic        start_go;   // Frame begins on this edge
    beat_cnt_t   in_cnt_q;
    beat_cnt_t   out_cnt_q;
    frame_cnt_t  frames_q;

    // ==================================================
    // Stream gating
    // ==================================================
    assign running   = (state_q == RUN);
    assign pk_in_vld = in_vld & running;
    assign in_rdy    = pk_in_rdy & running;
    assign in_fire   = pk_in_vld & pk_in_rdy;
    assign frame_end = (state_q == DRAIN) & out_fire & out_last;
    assign pk_clear  = (state_q == FLUSH);      // Cache cleared at end of FLUSH

    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE:    if (cfg.flush) state_d = FLUSH;
                     else if (cfg.start) state_d = RUN;
            RUN:     if (cfg.flush) state_d = FLUSH;
                     else if (in_fire && in_last) state_d = DRAIN;
            DRAIN:   if (cfg.flush) state_d = FLUSH;
                     else if (frame_end) state_d = IDLE;
            default: state_d = IDLE;            // FLUSH lasts one cycle
        endcase
    end

    assign start_go = (state_q == IDLE) & (state_d == RUN);

    // ==================================================
    // State, widths and counters
    // ==================================================
    always_ff @(posedge CLK or negedge RST_N) begin
        if (!RST_N) begin
            state_q    <= IDLE;
            run_in_bw  <= in_bw_t'(`BWC_IN_W);
            run_out_bw <= out_bw_t'(`BWC_OUT_W);
            in_cnt_q   <= '0;
            out_cnt_q  <= '0;
            frames_q   <= '0;
        end else begin
            state_q <= state_d;
            if (start_go) begin
                run_in_bw  <= cfg.in_bw;         // Held for the whole frame
                run_out_bw <= cfg.out_bw;
                in_cnt_q   <= '0;
                out_cnt_q  <= '0;
            end else begin
                if (in_fire) in_cnt_q <= in_cnt_q + 1'b1;
                if (out_fire && state_q != IDLE) out_cnt_q <= out_cnt_q + 1'b1;
            end
            if (frame_end) frames_q <= frames_q + 1'b1;
        end
    end

    assign stat = '{state:       state_q,
                    busy:        (state_q != IDLE),
                    frames_done: frames_q,
                    in_beats:    in_cnt_q,
                    out_beats:   out_cnt_q};

endmodule

`default_nettype wire

//--- design/bwc_packer.sv
`default_nettype none
`include "bwc_sys_params.svh"

module bwc_packer (
    input  wire                            CLK,
    input  wire                            RST_N,
    input  wire                            clear,
    input  wire bwc_stream_pkg::in_bw_t    in_bw,
    input  wire bwc_stream_pkg::out_bw_t   out_bw,
    input  wire                            in_vld,
    input  wire bwc_stream_pkg::in_beat_t  in_beat,
    input  wire                            out_rdy,
    output logic                           in_rdy,
    output logic                           out_vld,
    output bwc_stream_pkg::out_beat_t      out_beat
);
    import bwc_stream_pkg::*;

    // Ones in the low n bits of a cache word
    function automatic cache_t low_mask(input logic [8:0] n);
        return ~({`BWC_CACHE_W{1'b1}} << n);
    endfunction

    cache_t     cache_q;    // Bit 0 is the oldest bit
    cache_t     cache_sh;   // Cache after an output pop
    cache_t     cache_d;
    cache_t     in_keep;    // Input bits at the low end
    cache_t     ins_mask;   // Cache bits written by the input
    cache_t     out_bits;
    fill_t      fill_q;     // Valid bits in the cache
    fill_t      take;       // Bits leaving with the output beat
    fill_t      base;       // Insert position for the input
    logic [8:0] room_need;  // Fill after this cycle's input
    logic       last_q;     // Last input seen, cache not yet empty
    logic       in_fire;
    logic       out_fire;

    // ==================================================
    // Output side
    // ==================================================
    assign out_vld  = (fill_q >= out_bw) | (last_q & (fill_q != '0));
    assign take     = (fill_q >= out_bw) ? out_bw : fill_q;  // Partial tail beat
    assign out_fire = out_vld & out_rdy;

    assign out_bits      = cache_q & low_mask({1'b0, take});  // Zero pad above take
    assign out_beat.data = out_bits[`BWC_OUT_W-1:0];
    assign out_beat.last = last_q & (fill_q <= out_bw);

    // ==================================================
    // Input side
    // ==================================================
    assign base      = out_fire ? (fill_q - take) : fill_q;
    assign room_need = {1'b0, base} + {2'b00, in_bw};
    assign in_rdy    = (room_need <= 9'(`BWC_CACHE_W));  // May follow out_rdy
    assign in_fire   = in_vld & in_rdy;

    assign in_keep  = cache_t'(in_beat.data) & low_mask({2'b00, in_bw});
    assign ins_mask = low_mask({2'b00, in_bw}) << base;
    assign cache_sh = out_fire ? (cache_q >> out_bw) : cache_q;  // Pop first
    assign cache_d  = in_fire ? ((cache_sh & ~ins_mask) | (in_keep << base))
                              : cache_sh;

    // ==================================================
    // Storage
    // ==================================================
    always_ff @(posedge CLK or negedge RST_N) begin
        if (!RST_N) begin
            fill_q <= '0;
            last_q <= 1'b0;
        end else if (clear) begin
            fill_q <= '0;                        // Flush drops cached bits
            last_q <= 1'b0;
        end else begin
            fill_q <= in_fire ? fill_t'(room_need) : base;
            if (in_fire && in_beat.last) begin
                last_q <= 1'b1;
            end else if (out_fire && out_beat.last) begin
                last_q <= 1'b0;                  // Frame fully emitted
            end
        end
    end

    // Cache data follows cache_d each cycle
    always_ff @(posedge CLK) begin
        cache_q <= cache_d;
    end

endmodule

`default_nettype wire

//--- design/bwc_sys_top.sv
`default_nettype none
`include "bwc_sys_params.svh"

module bwc_sys_top (
    input  wire                           CLK,
    input  wire                           RST_N,
    input  wire                           wb_cyc,
    input  wire                           wb_stb,
    input  wire                           wb_we,
    input  wire [`BWC_WB_AW-1:0]          wb_adr,
    input  wire [31:0]                    wb_dat_w,
    input  wire [3:0]                     wb_sel,
    output logic [31:0]                   wb_dat_r,
    output logic                          wb_ack,
    input  wire                           in_vld,
    input  wire bwc_stream_pkg::in_beat_t in_beat,
    output logic                          in_rdy,
    output logic                          out_vld,
    output bwc_stream_pkg::out_beat_t     out_beat,
    input  wire                           out_rdy
);
    import bwc_ctrl_pkg::*;
    import bwc_stream_pkg::*;

    bwc_cfg_t  cfg;         // Register port to controller
    bwc_stat_t stat;        // Controller to register port
    in_bw_t    run_in_bw;   // Frame widths
    out_bw_t   run_out_bw;
    logic      pk_in_vld;   // Gated input valid
    logic      pk_in_rdy;
    logic      pk_clear;
    logic      out_fire;

    assign out_fire = out_vld & out_rdy;

    // ==================================================
    // Instances
    // ==================================================
    bwc_csr u_csr (
        .CLK(CLK), .RST_N(RST_N),
        .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we), .wb_adr(wb_adr),
        .wb_dat_w(wb_dat_w), .wb_sel(wb_sel), .stat(stat),
        .wb_dat_r(wb_dat_r), .wb_ack(wb_ack), .cfg(cfg)
    );

    bwc_ctrl u_ctrl (
        .CLK(CLK), .RST_N(RST_N), .cfg(cfg),
        .in_vld(in_vld), .in_last(in_beat.last), .pk_in_rdy(pk_in_rdy),
        .out_fire(out_fire), .out_last(out_beat.last),
        .pk_in_vld(pk_in_vld), .in_rdy(in_rdy), .pk_clear(pk_clear),
        .run_in_bw(run_in_bw), .run_out_bw(run_out_bw), .stat(stat)
    );

    bwc_packer u_packer (
        .CLK(CLK), .RST_N(RST_N), .clear(pk_clear),
        .in_bw(run_in_bw), .out_bw(run_out_bw),
        .in_vld(pk_in_vld), .in_beat(in_beat), .out_rdy(out_rdy),
        .in_rdy(pk_in_rdy), .out_vld(out_vld), .out_beat(out_beat)
    );

endmodule

`default_nettype wire

//--- tests/bwc_sys_sva.sv
`default_nettype none

module bwc_sys_sva (
    input wire         CLK,
    input wire         RST_N,
    input wire         wb_cyc,
    input wire         wb_stb,
    input wire         wb_ack,
    input wire         in_rdy,
    input wire         out_vld,
    input wire         out_rdy,
    input wire [128:0] out_beat,
    input wire         clear,
    input wire [7:0]   fill
);

    // ==================================================
    // Register port
    // ==================================================
    ack_one_cycle: assert property (@(posedge CLK) disable iff (!RST_N)
        wb_ack |=> !wb_ack)
        else $error("wb_ack held longer than one cycle");

    ack_in_cycle: assert property (@(posedge CLK) disable iff (!RST_N)
        wb_ack |-> (wb_cyc && wb_stb))
        else $error("wb_ack outside a bus cycle");

    // ==================================================
    // Output stream and cache
    // ==================================================
    // A flush may drop a held beat, so the FLUSH cycle is left out
    out_hold: assert property (@(posedge CLK) disable iff (!RST_N)
        (out_vld && !out_rdy && !clear) |=> (out_vld && $stable(out_beat)))
        else $error("out_beat changed while stalled");

    fill_bound: assert property (@(posedge CLK) disable iff (!RST_N)
        fill <= 8'd192)
        else $error("cache fill above 192 bits");

    reset_quiet: assert property (@(posedge CLK)
        !RST_N |-> (!out_vld && !in_rdy && !wb_ack))
        else $error("valid or ack high during reset");

endmodule

bind bwc_sys_top bwc_sys_sva u_sva (
    .CLK(CLK), .RST_N(RST_N),
    .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_ack(wb_ack),
    .in_rdy(in_rdy), .out_vld(out_vld), .out_rdy(out_rdy),
    .out_beat(out_beat), .clear(pk_clear), .fill(u_packer.fill_q)
);

`default_nettype wire

//--- tests/bwc_sys_tb.sv
`default_nettype none
`include "bwc_sys_params.svh"

module bwc_sys_tb;
    import bwc_stream_pkg::*;

    localparam int MAX_CYCLES = 4000;  // Worst case stalls plus margin

    logic CLK;
    logic RST_N;
    logic wb_cyc;
    logic wb_stb;
    logic wb_we;
    logic [`BWC_WB_AW-1:0] wb_adr;
    logic [31:0] wb_dat_w;
    logic [31:0] wb_dat_r;
    logic [3:0]  wb_sel;
    logic        wb_ack;
    logic        in_vld;
    logic        in_rdy;
    logic        out_vld;
    logic        out_rdy;
    in_beat_t    in_beat;
    out_beat_t   out_beat;

    logic [15:0]  rnd_st   = 16'd8746;  // Data, widths, input gaps
    logic [15:0]  stall_st = 16'd8746;  // out_rdy pattern
    int           stall_mode = 0;       // 0 ready, 1 random, 2 held low
    in_beat_t     frame_q[$];
    logic [128:0] exp_q[$];             // {data, last}
    string        test_name = "reset";
    int           mismatch_cnt = 0;
    int           fail_cnt = 0;
    int           cycles = 0;
    int           in_seen = 0;
    int           out_seen = 0;
    int           frames_exp = 0;

    bwc_sys_top uut (
        .CLK(CLK), .RST_N(RST_N),
        .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we), .wb_adr(wb_adr),
        .wb_dat_w(wb_dat_w), .wb_sel(wb_sel), .wb_dat_r(wb_dat_r), .wb_ack(wb_ack),
        .in_vld(in_vld), .in_beat(in_beat), .in_rdy(in_rdy),
        .out_vld(out_vld), .out_beat(out_beat), .out_rdy(out_rdy)
    );

    always #20 CLK = ~CLK;  // Period 40

    // ==================================================
    // LFSR with taps 16 14 13 11
    // ==================================================
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    function automatic logic [63:0] take_bits(input int n);
        logic [63:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            rnd_st = lfsr_next(rnd_st);
            v[i] = rnd_st[0];  // One step per bit
        end
        return v;
    endfunction

    always @(negedge CLK) begin
        case (stall_mode)
            1: begin
                stall_st = lfsr_next(stall_st);
                out_rdy <= stall_st[0];
            end
            2:       out_rdy <= 1'b0;
            default: out_rdy <= 1'b1;
        endcase
    end

    // Expected beats from the frame bit string sliced into obw chunks
    function automatic void ref_pack(input int ibw, input int obw);
        logic [127:0] acc;
        logic [128:0] tail;
        int           n;
        acc = '0;
        n = 0;
        foreach (frame_q[i]) begin
            for (int b = 0; b < ibw; b++) begin
                acc[n] = frame_q[i].data[b];
                n++;
                if (n == obw) begin
                    exp_q.push_back({acc, 1'b0});
                    acc = '0;
                    n = 0;
                end
            end
        end
        if (n > 0) begin
            exp_q.push_back({acc, 1'b1});  // Zero padded tail
        end else if (exp_q.size() > 0) begin
            tail = exp_q.pop_back();
            exp_q.push_back({tail[128:1], 1'b1});
        end
    endfunction

    // ==================================================
    // Comparing process and watchdog
    // ==================================================
    always @(posedge CLK) begin
        logic [128:0] exp_b;
        cycles++;
        if (in_vld && in_rdy) in_seen++;
        if (out_vld && out_rdy) begin
            out_seen++;
            if (exp_q.size() == 0) begin
                $display("%s: output beat arrived with none expected", test_name);
                fail_cnt++;
            end else begin
                exp_b = exp_q.pop_front();
                if (exp_b != out_beat) begin
                    $display("mismatch %s exp %h act %h", test_name, exp_b, out_beat);
                    mismatch_cnt++;
                end
            end
        end
        if (cycles >= MAX_CYCLES) begin
            $display("Timeout after %0d cycles in %s", cycles, test_name);
            $display("TEST FAIL");
            $finish;
        end
    end

    // ==================================================
    // Wishbone tasks
    // ==================================================
    task automatic wb_write(input int adr, input logic [31:0] dat);
        @(negedge CLK);
        wb_cyc = 1'b1;
        wb_stb = 1'b1;
        wb_we = 1'b1;
        wb_adr = adr[`BWC_WB_AW-1:0];
        wb_dat_w = dat;
        wb_sel = 4'hf;
        do @(posedge CLK); while (!wb_ack);
        @(negedge CLK);
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we = 1'b0;
    endtask

    task automatic wb_read(input int adr, output logic [31:0] dat);
        @(negedge CLK);
        wb_cyc = 1'b1;
        wb_stb = 1'b1;
        wb_we = 1'b0;
        wb_adr = adr[`BWC_WB_AW-1:0];
        do @(posedge CLK); while (!wb_ack);
        dat = wb_dat_r;
        @(negedge CLK);
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
    endtask

    task automatic check_reg(input int adr, input logic [31:0] exp_v, input string what);
        logic [31:0] v;
        wb_read(adr, v);
        if (v != exp_v) begin
            $display("mismatch %s/%s exp %h act %h", test_name, what, exp_v, v);
            mismatch_cnt++;
        end
    endtask

    // ==================================================
    // Stream driver and frame runner
    // ==================================================
    task automatic send_beats(input bit gaps);
        foreach (frame_q[i]) begin
            @(negedge CLK);
            while (gaps && take_bits(1)) begin
                in_vld = 1'b0;  // Random idle cycle
                @(negedge CLK);
            end
            in_vld = 1'b1;
            in_beat = frame_q[i];
            do @(posedge CLK); while (!in_rdy);
        end
        @(negedge CLK);
        in_vld = 1'b0;
    endtask

    task automatic wait_idle();
        logic [31:0] st;
        do wb_read(`BWC_REG_STATUS, st); while (st[2]);
    endtask

    task automatic run_frame(input string name, input int ibw, input int obw,
                             input int nbeats, input int mode, input bit mid_wr);
        test_name = name;
        stall_mode = mode;
        frame_q.delete();
        for (int i = 0; i < nbeats; i++) begin
            frame_q.push_back('{data: take_bits(64), last: (i == nbeats - 1)});
        end
        ref_pack(ibw, obw);
        wb_write(`BWC_REG_WIDTH, {16'd0, obw[7:0], 1'b0, ibw[6:0]});
        in_seen = 0;
        out_seen = 0;
        wb_write(`BWC_REG_CTRL, 32'd1);
        fork
            send_beats(mode == 1);
            if (mid_wr) wb_write(`BWC_REG_WIDTH, 32'h0000_0503);  // Ignored until next start
        join
        wait_idle();
        frames_exp++;
        if (exp_q.size() != 0) begin
            $display("%s: %0d expected beats never arrived", name, exp_q.size());
            fail_cnt++;
            exp_q.delete();
        end
        check_reg(`BWC_REG_IN_BEATS, in_seen, "in_beats");
        check_reg(`BWC_REG_OUT_BEATS, out_seen, "out_beats");
        check_reg(`BWC_REG_STATUS, {16'd0, frames_exp[7:0], 8'd0}, "status");
    endtask

    // ==================================================
    // Test sequence
    // ==================================================
    initial begin
        CLK = 1'b0;
        RST_N = 1'b1;
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we = 1'b0;
        wb_adr = '0;
        wb_dat_w = '0;
        wb_sel = '0;
        in_vld = 1'b0;
        in_beat = '0;
        out_rdy = 1'b1;
        #1;
        RST_N = 1'b0;  // Reset edge ahead of the first clock
        repeat (2) @(posedge CLK);
        @(negedge CLK);
        RST_N = 1'b1;

        if (out_vld || wb_ack) begin
            $display("out_vld or wb_ack high after reset");
            fail_cnt++;
        end
        check_reg(`BWC_REG_WIDTH, 32'h0000_8040, "width_default");
        check_reg(`BWC_REG_STATUS, 32'd0, "status");
        check_reg(`BWC_REG_IN_BEATS, 32'd0, "in_beats");
        check_reg(`BWC_REG_OUT_BEATS, 32'd0, "out_beats");
        wb_write(`BWC_REG_WIDTH, 32'h0000_2818);
        check_reg(`BWC_REG_WIDTH, 32'h0000_2818, "width_rw");

        run_frame("full_64_128", 64, 128, 8, 0, 1'b0);
        run_frame("odd_24_40", 24, 40, 13, 0, 1'b0);
        run_frame("odd_64_7", 64, 7, 5, 1, 1'b0);
        for (int k = 0; k < 3; k++) begin
            run_frame($sformatf("random_%0d", k), 1 + int'(take_bits(6)),
                      1 + int'(take_bits(7)), 3 + int'(take_bits(3)), 1, 1'b0);
        end
        run_frame("width_write_mid", 32, 48, 9, 1, 1'b1);

        // Partial frame held back and flushed
        test_name = "flush";
        stall_mode = 2;
        frame_q.delete();
        frame_q.push_back('{data: take_bits(64), last: 1'b0});
        frame_q.push_back('{data: take_bits(64), last: 1'b0});
        wb_write(`BWC_REG_WIDTH, 32'h0000_8040);
        wb_write(`BWC_REG_CTRL, 32'd1);
        send_beats(1'b0);
        wb_write(`BWC_REG_CTRL, 32'd2);
        check_reg(`BWC_REG_STATUS, {16'd0, frames_exp[7:0], 8'd0}, "status");
        run_frame("after_flush", 40, 24, 7, 1, 1'b0);

        $display("Errors: %0d mismatches, %0d other failures", mismatch_cnt, fail_cnt);
        if (mismatch_cnt == 0 && fail_cnt == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- bwc_sys.f
+incdir+design
design/bwc_stream_pkg.sv
design/bwc_ctrl_pkg.sv
design/bwc_csr.sv
design/bwc_ctrl.sv
design/bwc_packer.sv
design/bwc_sys_top.sv
tests/bwc_sys_sva.sv
tests/bwc_sys_tb.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0
LINTFLAGS ?= --lint-only --timing -Wall
TOP       := bwc_sys_tb
FILELIST  := bwc_sys.f
OBJDIR    := obj_dir
LOG       := sim.log

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)

run: build
	./$(OBJDIR)/V$(TOP) | tee $(LOG)
	@if grep -q "TEST FAIL" $(LOG); then exit 1; fi
	@grep -q "TEST PASS" $(LOG)

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJDIR) $(LOG)
